// File: common/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// Widths
	localparam int dataWidth = 32;
	localparam int addrWidth = 9; // 512 byte space
	localparam int regIdxWidth = 5;

	typedef logic [dataWidth-1:0] word;
	typedef logic [addrWidth-1:0] memAddr;
	typedef logic [regIdxWidth-1:0] regIdx;

	// Primary opcodes, MIPS encoding
	localparam logic [5:0] opRType = 6'b000000;
	localparam logic [5:0] opSpecial2 = 6'b011100;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opSlti = 6'b001010;
	localparam logic [5:0] opSltiu = 6'b001011;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri = 6'b001101;
	localparam logic [5:0] opXori = 6'b001110;
	localparam logic [5:0] opLui = 6'b001111;
	localparam logic [5:0] opLw = 6'b100011;
	localparam logic [5:0] opSw = 6'b101011;

	// Function field under opRType
	localparam logic [5:0] fnSll = 6'b000000;
	localparam logic [5:0] fnSrl = 6'b000010;
	localparam logic [5:0] fnSra = 6'b000011;
	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnXor = 6'b100110;
	localparam logic [5:0] fnNor = 6'b100111;
	localparam logic [5:0] fnSlt = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;
	localparam logic [5:0] fnClo = 6'b100001; // Under opSpecial2

	// ALU operation
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt,
		aluSltu, aluSll, aluSrl, aluSra, aluLui, aluClo
	} aluFn;

	// Same 32 bits seen as R-type or I-type
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			regIdx rs;
			regIdx rt;
			regIdx rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0] opcode;
			regIdx rs;
			regIdx rt;
			logic [15:0] imm;
		} iType;
	} instrWord;

	// Datapath mux selects
	localparam logic srcARs = 1'b0; // A from rs register
	localparam logic srcAShamt = 1'b1; // A from shift amount
	localparam logic srcBReg = 1'b0;
	localparam logic srcBImm = 1'b1;
	localparam logic dstRd = 1'b0;
	localparam logic dstRt = 1'b1;
	localparam logic wbAlu = 1'b0;
	localparam logic wbMem = 1'b1;

endpackage

`default_nettype wire

// File: hw/datapath/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input logic CLK,
	input mipsPkg::regIdx raddrA,
	input mipsPkg::regIdx raddrB,
	input mipsPkg::regIdx waddr,
	input mipsPkg::word wdata,
	input logic we,
	output mipsPkg::word rdataA,
	output mipsPkg::word rdataB
);
	import mipsPkg::*;

	word regs [0:(1 << regIdxWidth)-1];

	// Asynchronous reads, $zero forced
	assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
	assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

	// Single write port
	always_ff @(posedge CLK) begin
		if (we && waddr != '0) // Writes to $zero dropped
			regs[waddr] <= wdata;
	end

endmodule

`default_nettype wire

// File: hw/datapath/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input mipsPkg::aluFn fn,
	input mipsPkg::word a,
	input mipsPkg::word b,
	output mipsPkg::word y
);
	import mipsPkg::*;

	logic [$clog2(dataWidth):0] onesCount; // Up to 32 needs 6 bits
	logic onesRun;
	logic [$clog2(dataWidth)-1:0] shAmt;

	assign shAmt = a[$clog2(dataWidth)-1:0]; // Low five bits of A

	// Leading ones from the MSB, stops at first zero
	always_comb begin
		onesCount = '0;
		onesRun = 1'b1;
		for (int i = dataWidth - 1; i >= 0; i--) begin
			if (onesRun && a[i])
				onesCount = onesCount + 1'b1;
			else
				onesRun = 1'b0;
		end
	end

	always_comb begin
		case (fn)
			aluAdd: y = a + b;
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr: y = a | b;
			aluXor: y = a ^ b;
			aluNor: y = ~(a | b);
			aluSlt: y = word'($signed(a) < $signed(b));
			aluSltu: y = word'(a < b);
			aluSll: y = b << shAmt;
			aluSrl: y = b >> shAmt;
			aluSra: y = $signed(b) >>> shAmt; // Sign bit repeated
			aluLui: y = b << 16;
			aluClo: y = word'(onesCount);
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/datapath/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath (
	input logic CLK,
	input logic reset,
	input mipsPkg::word memRData,
	input logic irLoad,
	input logic pcIncr,
	input logic opLoad,
	input logic resLoad,
	input logic mdrLoad,
	input logic regWrite,
	input logic addrSel,
	input logic srcASel,
	input logic srcBSel,
	input logic dstSel,
	input logic wbSel,
	input logic immZero,
	input mipsPkg::aluFn aluSel,
	output mipsPkg::instrWord instr,
	output mipsPkg::memAddr memAddress,
	output mipsPkg::word memWData
);
	import mipsPkg::*;

	memAddr pc;
	instrWord ir;
	word aReg, bReg; // Operands latched in decode
	word result;
	word mdr;
	word rdataA, rdataB;
	word immExt;
	word aluA, aluB, aluY;
	word wbData;
	regIdx waddr;

	// Zero or sign extension of the 16-bit immediate
	assign immExt = immZero ? {{(dataWidth - 16){1'b0}}, ir.iType.imm}
		: {{(dataWidth - 16){ir.iType.imm[15]}}, ir.iType.imm};

	assign aluA = (srcASel == srcAShamt) ? word'(ir.rType.shamt) : aReg;
	assign aluB = (srcBSel == srcBImm) ? immExt : bReg;
	assign waddr = (dstSel == dstRd) ? ir.rType.rd : ir.rType.rt;
	assign wbData = (wbSel == wbMem) ? mdr : result;

	assign instr = ir;
	assign memAddress = addrSel ? result[addrWidth-1:0] : pc; // Data access or fetch
	assign memWData = bReg; // rt value for sw

	registerFile regFile (
		.CLK(CLK),
		.raddrA(ir.rType.rs),
		.raddrB(ir.rType.rt),
		.waddr(waddr),
		.wdata(wbData),
		.we(regWrite),
		.rdataA(rdataA),
		.rdataB(rdataB)
	);

	alu aluUnit (
		.fn(aluSel),
		.a(aluA),
		.b(aluB),
		.y(aluY)
	);

	always_ff @(posedge CLK) begin
		if (reset)
			pc <= '0;
		else if (pcIncr)
			pc <= pc + memAddr'(4); // Next word
	end

	// Payload registers
	always_ff @(posedge CLK) begin
		if (irLoad)
			ir <= memRData;
		if (opLoad) begin
			aReg <= rdataA;
			bReg <= rdataB;
		end
		if (resLoad)
			result <= aluY;
		if (mdrLoad)
			mdr <= memRData;
	end

endmodule

`default_nettype wire

// File: hw/control/controlFsm.sv
`timescale 1ns/1ns
`default_nettype none

module controlFsm (
	input logic CLK,
	input logic reset,
	input mipsPkg::instrWord instr,
	input logic memDone,
	output logic memRead,
	output logic memWrite,
	output logic irLoad,
	output logic pcIncr,
	output logic opLoad,
	output logic resLoad,
	output logic mdrLoad,
	output logic regWrite,
	output logic addrSel,
	output logic srcASel,
	output logic srcBSel,
	output logic dstSel,
	output logic wbSel,
	output logic immZero,
	output mipsPkg::aluFn aluSel
);
	import mipsPkg::*;

	typedef enum logic [2:0] {
		stIdle, stFetch, stDecode, stExecute, stWriteBack, stMemRead, stMemWrite
	} fsmState;

	fsmState state, nextState;
	logic instrKnown;
	logic isLoad, isStore;

	assign isLoad = (instr.iType.opcode == opLw);
	assign isStore = (instr.iType.opcode == opSw);

	// Opcode and function decode, selects follow the IR directly
	always_comb begin
		srcASel = srcARs;
		srcBSel = srcBImm; // I-type by default
		dstSel = dstRt;
		wbSel = wbAlu;
		immZero = 1'b0;
		aluSel = aluAdd;
		instrKnown = 1'b1;
		case (instr.rType.opcode)
			opRType: begin
				srcBSel = srcBReg;
				dstSel = dstRd;
				case (instr.rType.funct)
					fnAdd, fnAddu: aluSel = aluAdd; // No overflow trap
					fnSub, fnSubu: aluSel = aluSub;
					fnAnd: aluSel = aluAnd;
					fnOr: aluSel = aluOr;
					fnXor: aluSel = aluXor;
					fnNor: aluSel = aluNor;
					fnSlt: aluSel = aluSlt;
					fnSltu: aluSel = aluSltu;
					fnSll: begin
						aluSel = aluSll;
						srcASel = srcAShamt;
					end
					fnSrl: begin
						aluSel = aluSrl;
						srcASel = srcAShamt;
					end
					fnSra: begin
						aluSel = aluSra;
						srcASel = srcAShamt;
					end
					default: instrKnown = 1'b0;
				endcase
			end
			opSpecial2: begin
				srcBSel = srcBReg;
				dstSel = dstRd;
				aluSel = aluClo;
				instrKnown = (instr.rType.funct == fnClo); // Only clo here
			end
			opAddiu: aluSel = aluAdd;
			opSlti: aluSel = aluSlt;
			opSltiu: aluSel = aluSltu; // Imm still sign extended
			opAndi: begin
				aluSel = aluAnd;
				immZero = 1'b1;
			end
			opOri: begin
				aluSel = aluOr;
				immZero = 1'b1;
			end
			opXori: begin
				aluSel = aluXor;
				immZero = 1'b1;
			end
			opLui: aluSel = aluLui;
			opLw: wbSel = wbMem; // Address add, data from MDR
			opSw: aluSel = aluAdd;
			default: instrKnown = 1'b0; // Treated as no-op
		endcase
	end

	// Strobes and next state
	always_comb begin
		nextState = state;
		memRead = 1'b0;
		memWrite = 1'b0;
		irLoad = 1'b0;
		pcIncr = 1'b0;
		opLoad = 1'b0;
		resLoad = 1'b0;
		mdrLoad = 1'b0;
		regWrite = 1'b0;
		addrSel = 1'b0; // PC on the bus
		case (state)
			stIdle: nextState = stFetch;
			stFetch: begin
				memRead = 1'b1;
				if (memDone) begin
					irLoad = 1'b1;
					pcIncr = 1'b1;
					nextState = stDecode;
				end
			end
			stDecode: begin
				opLoad = 1'b1;
				nextState = instrKnown ? stExecute : stFetch;
			end
			stExecute: begin
				resLoad = 1'b1;
				if (isLoad)
					nextState = stMemRead;
				else if (isStore)
					nextState = stMemWrite;
				else
					nextState = stWriteBack;
			end
			stMemRead: begin
				memRead = 1'b1;
				addrSel = 1'b1; // Result reg holds address
				if (memDone) begin
					mdrLoad = 1'b1;
					nextState = stWriteBack;
				end
			end
			stMemWrite: begin
				memWrite = 1'b1;
				addrSel = 1'b1;
				if (memDone)
					nextState = stFetch;
			end
			stWriteBack: begin
				regWrite = 1'b1;
				nextState = stFetch;
			end
			default: nextState = stIdle;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset)
			state <= stIdle;
		else
			state <= nextState;
	end

endmodule

`default_nettype wire

// File: hw/mipsCore.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore (
	input logic CLK,
	input logic reset,
	output mipsPkg::memAddr memAddress,
	output mipsPkg::word memWData,
	output logic memRead,
	output logic memWrite,
	input mipsPkg::word memRData,
	input logic memDone
);
	import mipsPkg::*;

	instrWord instr;
	aluFn aluSel;
	logic irLoad, pcIncr, opLoad, resLoad, mdrLoad, regWrite;
	logic addrSel, srcASel, srcBSel, dstSel, wbSel, immZero;

	// Sequencer
	controlFsm control (
		.CLK(CLK), .reset(reset), .instr(instr), .memDone(memDone),
		.memRead(memRead), .memWrite(memWrite),
		.irLoad(irLoad), .pcIncr(pcIncr), .opLoad(opLoad), .resLoad(resLoad),
		.mdrLoad(mdrLoad), .regWrite(regWrite), .addrSel(addrSel),
		.srcASel(srcASel), .srcBSel(srcBSel), .dstSel(dstSel), .wbSel(wbSel),
		.immZero(immZero), .aluSel(aluSel)
	);

	// Registers, ALU and memory address path
	datapath dataPath (
		.CLK(CLK), .reset(reset), .memRData(memRData),
		.irLoad(irLoad), .pcIncr(pcIncr), .opLoad(opLoad), .resLoad(resLoad),
		.mdrLoad(mdrLoad), .regWrite(regWrite), .addrSel(addrSel),
		.srcASel(srcASel), .srcBSel(srcBSel), .dstSel(dstSel), .wbSel(wbSel),
		.immZero(immZero), .aluSel(aluSel),
		.instr(instr), .memAddress(memAddress), .memWData(memWData)
	);

endmodule

`default_nettype wire

// File: verif/tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock (
	output logic CLK
);

	// 40 ns period, starts low
	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

endmodule

`default_nettype wire

// File: verif/mipsCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCoreTb;
	import mipsPkg::*;

	localparam int rowCount = 6;
	localparam int storeTimeout = 400; // Cycles allowed per program

	logic CLK;
	logic reset = 1'b1;
	memAddr memAddress;
	word memWData;
	logic memRead;
	logic memWrite;
	word memRData = '0;
	logic memDone = 1'b0;

	word mem [0:127]; // 512-byte memory image
	instrWord prog [0:rowCount-1][0:7];
	word preload [0:rowCount-1]; // Word at 0x100
	logic usePreload [0:rowCount-1];
	memAddr expAddr [0:rowCount-1];
	word expData [0:rowCount-1];

	int curRow = 0;
	int storesDone = 0;
	memAddr expectedPc = '0;
	logic busy = 1'b0;
	int waitLeft = 0;
	logic [7:0] lfsr = 8'd18;
	logic [1:0] delayBits;

	tbClock clockGen (.CLK(CLK));

	mipsCore UUT (
		.CLK(CLK), .reset(reset), .memAddress(memAddress), .memWData(memWData),
		.memRead(memRead), .memWrite(memWrite), .memRData(memRData), .memDone(memDone)
	);

	// Fibonacci LFSR with taps 8 6 5 4
	function automatic logic [7:0] lfsrStep(input logic [7:0] state);
		return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
	endfunction

	function automatic instrWord encodeR(input logic [5:0] op, input regIdx rs, input regIdx rt,
		input regIdx rd, input logic [4:0] shamt, input logic [5:0] funct);
		instrWord ins;
		ins.rType = '{op, rs, rt, rd, shamt, funct};
		return ins;
	endfunction

	function automatic instrWord encodeI(input logic [5:0] op, input regIdx rs, input regIdx rt,
		input logic [15:0] imm);
		instrWord ins;
		ins.iType = '{op, rs, rt, imm};
		return ins;
	endfunction

	task automatic stopWithFailure();
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkFetch(input memAddr got, input memAddr expected);
		if (got !== expected) begin
			$display("ERR %0t: fetch from %h, expected %h", $time, got, expected);
			stopWithFailure();
		end
	endtask

	task automatic checkStore(input memAddr gotAddr, input word gotData,
		input memAddr wantAddr, input word wantData);
		if (gotAddr !== wantAddr || gotData !== wantData) begin
			$display("ERR %0t: store %h to %h, expected %h to %h", $time,
				gotData, gotAddr, wantData, wantAddr);
			stopWithFailure();
		end
	endtask

	task automatic checkStrobes(input logic gotRead, input logic gotWrite,
		input logic wantRead, input logic wantWrite);
		if (gotRead !== wantRead || gotWrite !== wantWrite) begin
			$display("ERR %0t: memRead %b memWrite %b, expected %b %b", $time,
				gotRead, gotWrite, wantRead, wantWrite);
			stopWithFailure();
		end
	endtask

	task automatic buildTable();
		for (int r = 0; r < rowCount; r++) begin
			for (int i = 0; i < 8; i++)
				prog[r][i] = 32'hA5A50000 | word'(i << 2); // Never fetched
			usePreload[r] = 1'b0;
			preload[r] = '0;
		end
		// add, sub and their unsigned forms
		prog[0][0] = encodeI(opLui, 0, 1, 16'h1234);
		prog[0][1] = encodeI(opAddiu, 1, 1, 16'h5678); // 0x12345678
		prog[0][2] = encodeI(opAddiu, 0, 2, 16'hFFF0); // -16
		prog[0][3] = encodeR(opRType, 1, 2, 3, 0, fnAdd); // 0x12345668
		prog[0][4] = encodeR(opRType, 3, 2, 4, 0, fnSub); // 0x12345678
		prog[0][5] = encodeR(opRType, 4, 3, 5, 0, fnAddu); // 0x2468ACE0
		prog[0][6] = encodeR(opRType, 5, 2, 6, 0, fnSubu);
		prog[0][7] = encodeI(opSw, 0, 6, 16'h0104);
		expAddr[0] = 9'h104;
		expData[0] = 32'h2468ACF0;
		// Logic group
		prog[1][0] = encodeI(opLui, 0, 1, 16'hF0F0);
		prog[1][1] = encodeI(opAddiu, 0, 2, 16'h7F0F);
		prog[1][2] = encodeR(opRType, 1, 2, 3, 0, fnOr); // 0xF0F07F0F
		prog[1][3] = encodeR(opRType, 3, 0, 4, 0, fnNor); // 0x0F0F80F0
		prog[1][4] = encodeR(opRType, 4, 1, 5, 0, fnXor); // 0xFFFF80F0
		prog[1][5] = encodeI(opOri, 3, 6, 16'h3CC3); // 0xF0F07FCF
		prog[1][6] = encodeR(opRType, 5, 6, 7, 0, fnAnd);
		prog[1][7] = encodeI(opSw, 0, 7, 16'h0108);
		expAddr[1] = 9'h108;
		expData[1] = 32'hF0F000C0;
		// Immediate extension
		prog[2][0] = encodeI(opAddiu, 0, 1, 16'h8001); // 0xFFFF8001
		prog[2][1] = encodeI(opXori, 1, 2, 16'h8FFF); // 0xFFFF0FFE
		prog[2][2] = encodeI(opAndi, 2, 3, 16'hF0F6); // 0x000000F6
		prog[2][3] = encodeI(opOri, 3, 4, 16'h9300); // 0x000093F6
		prog[2][4] = encodeR(opRType, 4, 2, 5, 0, fnAddu);
		prog[2][5] = encodeI(opSltiu, 4, 6, 16'h8000); // 1 against 0xFFFF8000 unsigned
		prog[2][6] = encodeI(opSw, 6, 5, 16'h010B); // sltiu result is the base
		expAddr[2] = 9'h10C;
		expData[2] = 32'hFFFFA3F4;
		// Signed vs unsigned compares on negative operands
		prog[3][0] = encodeI(opAddiu, 0, 1, 16'hFFFE);
		prog[3][1] = encodeR(opRType, 1, 0, 2, 0, fnSlt); // 1
		prog[3][2] = encodeR(opRType, 0, 1, 3, 0, fnSltu); // 1
		prog[3][3] = encodeI(opSlti, 0, 4, 16'hFFFF); // 0 as imm is -1
		prog[3][4] = encodeI(opSltiu, 1, 5, 16'hFFFF); // 1 as imm is 0xFFFFFFFF
		prog[3][5] = encodeR(opRType, 2, 3, 6, 0, fnAddu);
		prog[3][6] = encodeR(opRType, 6, 4, 6, 0, fnAddu);
		prog[3][7] = encodeI(opSw, 5, 6, 16'h010F); // sltiu result is the base
		expAddr[3] = 9'h110;
		expData[3] = 32'd2;
		// Shifts, lui and clo
		prog[4][0] = encodeI(opLui, 0, 1, 16'h8765);
		prog[4][1] = encodeI(opOri, 1, 1, 16'h4321);
		prog[4][2] = encodeR(opRType, 0, 1, 2, 4, fnSra); // 0xF8765432
		prog[4][3] = encodeR(opRType, 0, 2, 3, 8, fnSrl); // 0x00F87654
		prog[4][4] = encodeR(opRType, 0, 3, 4, 12, fnSll); // 0x87654000
		prog[4][5] = encodeR(opSpecial2, 2, 5, 5, 0, fnClo); // 5
		prog[4][6] = encodeR(opRType, 4, 5, 6, 0, fnAddu);
		prog[4][7] = encodeI(opSw, 0, 6, 16'h0114);
		expAddr[4] = 9'h114;
		expData[4] = 32'h87654005;
		// Load, $zero write, clo of 0 and all ones
		prog[5][0] = encodeI(opLw, 0, 1, 16'h0100);
		prog[5][1] = encodeI(opAddiu, 0, 0, 16'hFFFF); // Dropped
		prog[5][2] = encodeR(opSpecial2, 0, 2, 2, 0, fnClo); // 0
		prog[5][3] = encodeI(opAddiu, 2, 3, 16'hFFFF);
		prog[5][4] = encodeR(opSpecial2, 3, 4, 4, 0, fnClo); // 32
		prog[5][5] = encodeR(opSpecial2, 1, 5, 5, 0, fnClo); // 13
		prog[5][6] = encodeR(opRType, 1, 5, 6, 0, fnAddu);
		prog[5][7] = encodeI(opSw, 4, 6, 16'h00F8); // 32 + 0xF8
		usePreload[5] = 1'b1;
		preload[5] = 32'hFFF80000;
		expAddr[5] = 9'h118;
		expData[5] = 32'hFFF8000D;
	endtask

	task automatic loadProgram(input int row);
		for (int i = 0; i < 128; i++)
			mem[i] = 32'hA5A50000 | word'(i << 2);
		for (int i = 0; i < 8; i++)
			mem[i] = prog[row][i];
		if (usePreload[row])
			mem[64] = preload[row]; // Byte address 0x100
	endtask

	// Memory model answering in one to four cycles
	always @(posedge CLK) begin
		#2;
		memDone = 1'b0;
		if (reset) begin
			busy = 1'b0;
			expectedPc = '0;
		end else if (busy) begin
			waitLeft = waitLeft - 1;
			if (waitLeft == 0) begin
				busy = 1'b0;
				memDone = 1'b1; // One-cycle pulse
				if (memWrite) begin
					checkStrobes(memRead, memWrite, 1'b0, 1'b1);
					checkStore(memAddress, memWData, expAddr[curRow], expData[curRow]);
					storesDone = storesDone + 1;
				end else begin
					if (memAddress < 9'h100) begin // Instruction fetch
						checkFetch(memAddress, expectedPc);
						expectedPc = expectedPc + 9'd4;
					end
					memRData = mem[memAddress[8:2]];
				end
			end
		end else if (memRead || memWrite) begin
			delayBits[0] = lfsr[7];
			lfsr = lfsrStep(lfsr);
			delayBits[1] = lfsr[7];
			lfsr = lfsrStep(lfsr);
			waitLeft = delayBits + 1;
			busy = 1'b1;
		end
	end

	initial begin
		int cycles;
		int storesBefore;
		buildTable();
		for (int row = 0; row < rowCount; row++) begin
			@(posedge CLK);
			#1;
			reset = 1'b1;
			curRow = row;
			loadProgram(row);
			for (int i = 0; i < 16; i++) begin // Bus quiet during reset
				@(posedge CLK);
				#1;
				checkStrobes(memRead, memWrite, 1'b0, 1'b0);
			end
			storesBefore = storesDone;
			reset = 1'b0;
			cycles = 0;
			while (storesDone == storesBefore) begin
				if (cycles == storeTimeout) begin
					$display("Timed out waiting for the store of program %0d", row);
					stopWithFailure();
				end
				@(posedge CLK);
				#1;
				cycles++;
			end
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
common/mipsPkg.sv
hw/datapath/registerFile.sv
hw/datapath/alu.sv
hw/datapath/datapath.sv
hw/control/controlFsm.sv
hw/mipsCore.sv
verif/tbClock.sv
verif/mipsCoreTb.sv

// File: Makefile
SOURCES = $(shell cat compile.f)

.PHONY: all run clean

all: obj_dir/VmipsCoreTb

# Rebuilt only when a source or the file list changes
obj_dir/VmipsCoreTb: compile.f $(SOURCES)
	verilator --binary --timing --top-module mipsCoreTb -f compile.f

# Pass or fail taken from the log
run: obj_dir/VmipsCoreTb
	-./obj_dir/VmipsCoreTb | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
